// ==== design/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef struct packed {
    logic              req;   // One read per cycle in which this is high.
    logic [ADDR_W-1:0] addr;
  } mem_rd_req_t;

  // The memory answers one cycle after the request, without stalls.
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } mem_rd_rsp_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_wr_req_t;

endpackage

`default_nettype wire

// ==== design/stream_addressgen.sv ====
`default_nettype none

module stream_addressgen #(
  parameter int unsigned ADDR_WIDTH   = 32,
  parameter int unsigned WORD_STRIDE  = 4,
  parameter int unsigned COUNTER_BITS = stream_pkg::COUNTER_BITS_DEF
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       en_i,
  input  wire logic                       inc_i,
  input  wire stream_pkg::stream_config_t cfg_i,
  output logic [ADDR_WIDTH-1:0]           addr_o,
  output stream_pkg::stream_flags_t       flags_o
);

  localparam logic [ADDR_WIDTH-1:0] ALIGN_MASK = ADDR_WIDTH'(WORD_STRIDE - 1);

  logic [COUNTER_BITS-1:0] line_len_m1;
  logic [COUNTER_BITS-1:0] feat_len_m1;
  logic [COUNTER_BITS:0]   trans_size;
  logic [ADDR_WIDTH-1:0]   base_addr;
  logic [ADDR_WIDTH-1:0]   line_step;
  logic [ADDR_WIDTH-1:0]   feat_step;
  logic [COUNTER_BITS-1:0] word_cnt;
  logic [COUNTER_BITS-1:0] line_cnt;
  logic [COUNTER_BITS-1:0] feat_cnt;
  logic [COUNTER_BITS:0]   overall_cnt;
  logic [COUNTER_BITS:0]   overall_nxt;
  logic [ADDR_WIDTH-1:0]   word_off;
  logic [ADDR_WIDTH-1:0]   line_off;
  logic [ADDR_WIDTH-1:0]   feat_off;
  logic                    line_wrap;
  logic                    feat_wrap;
  logic                    in_progress_q;

  assign line_len_m1 = COUNTER_BITS'(cfg_i.line_length - 16'd1);
  assign feat_len_m1 = COUNTER_BITS'(cfg_i.feat_length - 16'd1);
  assign trans_size  = (COUNTER_BITS+1)'(cfg_i.trans_size);
  assign base_addr   = ADDR_WIDTH'(cfg_i.base_addr);

  // Both strides are signed byte offsets.
  assign line_step = {{(ADDR_WIDTH-16){cfg_i.line_stride[15]}}, cfg_i.line_stride};
  assign feat_step = {{(ADDR_WIDTH-16){cfg_i.feat_stride[15]}}, cfg_i.feat_stride};

  // The last word of a line moves to the next line, the last line of a
  // feature moves to the next feature.
  assign line_wrap = !(word_cnt < line_len_m1);
  assign feat_wrap = line_wrap && !(line_cnt < feat_len_m1);

  assign overall_nxt = overall_cnt + (COUNTER_BITS+1)'(inc_i);

  assign flags_o.word_update = inc_i;
  assign flags_o.line_update = inc_i && line_wrap;
  assign flags_o.feat_update = inc_i && feat_wrap;
  assign flags_o.in_progress = in_progress_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt    <= '0;
      line_cnt    <= '0;
      feat_cnt    <= '0;
      overall_cnt <= '0;
      word_off    <= '0;
      line_off    <= '0;
      feat_off    <= '0;
    end else if (!en_i) begin
      // A disabled generator starts the next stream from its base.
      word_cnt    <= '0;
      line_cnt    <= '0;
      feat_cnt    <= '0;
      overall_cnt <= '0;
      word_off    <= '0;
      line_off    <= '0;
      feat_off    <= '0;
    end else if (inc_i) begin
      overall_cnt <= overall_nxt;
      if (!line_wrap) begin
        word_cnt <= word_cnt + 1'b1;
        word_off <= word_off + ADDR_WIDTH'(WORD_STRIDE);
      end else if (!feat_wrap) begin
        word_cnt <= '0;
        word_off <= '0;
        line_cnt <= line_cnt + 1'b1;
        line_off <= line_off + line_step;
      end else begin
        word_cnt <= '0;
        word_off <= '0;
        line_cnt <= '0;
        line_off <= '0;
        feat_cnt <= feat_cnt + 1'b1;
        feat_off <= feat_off + feat_step;
      end
    end
  end

  // Low in the first enabled cycle, so it rises one cycle after enable.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_progress_q <= 1'b0;
    end else begin
      in_progress_q <= en_i && (overall_nxt < trans_size);
    end
  end

  assign addr_o = base_addr + word_off + line_off + feat_off;

  a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (en_i && (((base_addr | line_step | feat_step) & ALIGN_MASK) == '0))
    |-> ((addr_o & ALIGN_MASK) == '0))
    else $error("Generated address lost word alignment.");

  a_no_inc_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    !en_i |-> !inc_i)
    else $error("Step requested while the generator is disabled.");

  // The three level counters always decompose the overall count.
  a_count_split: assert property (@(posedge clk) disable iff (!rst_n)
    en_i |-> (64'(feat_cnt) * 64'(cfg_i.line_length) * 64'(cfg_i.feat_length)
              + 64'(line_cnt) * 64'(cfg_i.line_length) + 64'(word_cnt)
              == 64'(overall_cnt)))
    else $error("Level counters disagree with the overall count.");

endmodule

`default_nettype wire

// ==== design/stream_copy_top.sv ====
`default_nettype none

module stream_copy_top #(
  parameter int unsigned ADDR_WIDTH   = 32,
  parameter int unsigned DATA_WIDTH   = 32,
  parameter int unsigned WORD_STRIDE  = 4,
  parameter int unsigned COUNTER_BITS = stream_pkg::COUNTER_BITS_DEF
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       start_i,
  input  wire stream_pkg::stream_config_t src_cfg_i,
  input  wire stream_pkg::stream_config_t dst_cfg_i,
  output mem_pkg::mem_rd_req_t            mem_rd_req_o,
  input  wire mem_pkg::mem_rd_rsp_t       mem_rd_rsp_i,
  output mem_pkg::mem_wr_req_t            mem_wr_req_o,
  output logic                            busy_o,
  output logic                            done_o
);

  stream_pkg::stream_config_t src_cfg;
  stream_pkg::stream_config_t dst_cfg;
  logic                       enable;
  logic                       src_finished;
  logic                       dst_finished;
  logic                       data_valid;
  logic [DATA_WIDTH-1:0]      data;

  stream_ctrl i_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .src_cfg_i      (src_cfg_i),
    .dst_cfg_i      (dst_cfg_i),
    .src_finished_i (src_finished),
    .dst_finished_i (dst_finished),
    .src_cfg_o      (src_cfg),
    .dst_cfg_o      (dst_cfg),
    .enable_o       (enable),
    .busy_o         (busy_o),
    .done_o         (done_o)
  );

  stream_source #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .DATA_WIDTH   (DATA_WIDTH),
    .WORD_STRIDE  (WORD_STRIDE),
    .COUNTER_BITS (COUNTER_BITS)
  ) i_source (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (enable),
    .cfg_i        (src_cfg),
    .mem_rd_rsp_i (mem_rd_rsp_i),
    .mem_rd_req_o (mem_rd_req_o),
    .data_valid_o (data_valid),
    .data_o       (data),
    .finished_o   (src_finished)
  );

  stream_sink #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .DATA_WIDTH   (DATA_WIDTH),
    .WORD_STRIDE  (WORD_STRIDE),
    .COUNTER_BITS (COUNTER_BITS)
  ) i_sink (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (enable),
    .cfg_i        (dst_cfg),
    .data_valid_i (data_valid),
    .data_i       (data),
    .mem_wr_req_o (mem_wr_req_o),
    .finished_o   (dst_finished)
  );

endmodule

`default_nettype wire

// ==== design/stream_ctrl.sv ====
`default_nettype none

module stream_ctrl (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       start_i,
  input  wire stream_pkg::stream_config_t src_cfg_i,
  input  wire stream_pkg::stream_config_t dst_cfg_i,
  input  wire logic                       src_finished_i,
  input  wire logic                       dst_finished_i,
  output stream_pkg::stream_config_t      src_cfg_o,
  output stream_pkg::stream_config_t      dst_cfg_o,
  output logic                            enable_o,
  output logic                            busy_o,
  output logic                            done_o
);

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e                     state_q;
  logic                       done_q;
  stream_pkg::stream_config_t src_cfg_q;
  stream_pkg::stream_config_t dst_cfg_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: if (start_i) state_q <= BUSY;
        BUSY: begin
          // Both sides must be through before the copy counts as done.
          if (src_finished_i && dst_finished_i) begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Configurations are taken only by a start while idle.
  always_ff @(posedge clk) begin
    if (state_q == IDLE && start_i) begin
      src_cfg_q <= src_cfg_i;
      dst_cfg_q <= dst_cfg_i;
    end
  end

  assign src_cfg_o = src_cfg_q;
  assign dst_cfg_o = dst_cfg_q;
  assign enable_o  = (state_q == BUSY);  // Dropping it clears both generators.
  assign busy_o    = (state_q == BUSY);
  assign done_o    = done_q;

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |=> !done_o)
    else $error("Done lasted longer than one cycle.");

endmodule

`default_nettype wire

// ==== design/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

  // Default width of the word, line, feature and overall counters.
  localparam int unsigned COUNTER_BITS_DEF = 16;

  // One stream description, laid out as four 32-bit words.
  typedef struct packed {
    logic        [31:0] base_addr;    // Byte address of the first word.
    logic        [15:0] trans_size;   // Words in the whole transfer.
    logic        [15:0] line_length;  // Words per line.
    logic signed [15:0] line_stride;  // Byte step from one line start to the next.
    logic        [15:0] feat_length;  // Lines per feature.
    logic signed [15:0] feat_stride;  // Byte step from one feature start to the next.
    logic        [15:0] rsvd;         // Pads the last word.
  } stream_config_t;

  // Step flags of one address generator.
  // The update bits show which levels move on the current step.
  typedef struct packed {
    logic word_update;
    logic line_update;
    logic feat_update;
    logic in_progress;  // High while steps are still due.
  } stream_flags_t;

endpackage

`default_nettype wire

// ==== design/stream_sink.sv ====
`default_nettype none

module stream_sink #(
  parameter int unsigned ADDR_WIDTH   = 32,
  parameter int unsigned DATA_WIDTH   = 32,
  parameter int unsigned WORD_STRIDE  = 4,
  parameter int unsigned COUNTER_BITS = stream_pkg::COUNTER_BITS_DEF
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       en_i,
  input  wire stream_pkg::stream_config_t cfg_i,
  input  wire logic                       data_valid_i,
  input  wire logic [DATA_WIDTH-1:0]      data_i,
  output mem_pkg::mem_wr_req_t            mem_wr_req_o,
  output logic                            finished_o
);

  stream_pkg::stream_flags_t gen_flags;
  logic [ADDR_WIDTH-1:0]     gen_addr;
  logic                      accept;
  logic                      en_q;

  // A strobe past the end of the destination stream is dropped.
  assign accept = en_i && data_valid_i && gen_flags.in_progress;

  stream_addressgen #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .WORD_STRIDE  (WORD_STRIDE),
    .COUNTER_BITS (COUNTER_BITS)
  ) i_addrgen (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (en_i),
    .inc_i   (accept),
    .cfg_i   (cfg_i),
    .addr_o  (gen_addr),
    .flags_o (gen_flags)
  );

  // The write leaves in the cycle of the strobe.
  assign mem_wr_req_o.req   = accept;
  assign mem_wr_req_o.addr  = gen_addr;
  assign mem_wr_req_o.wdata = data_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q <= 1'b0;
    end else begin
      en_q <= en_i;
    end
  end

  assign finished_o = en_q && !gen_flags.in_progress;  // Last write has gone out.

  a_no_late_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    data_valid_i |-> gen_flags.in_progress)
    else $error("Data strobe arrived after the destination stream finished.");

endmodule

`default_nettype wire

// ==== design/stream_source.sv ====
`default_nettype none

module stream_source #(
  parameter int unsigned ADDR_WIDTH   = 32,
  parameter int unsigned DATA_WIDTH   = 32,
  parameter int unsigned WORD_STRIDE  = 4,
  parameter int unsigned COUNTER_BITS = stream_pkg::COUNTER_BITS_DEF
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       en_i,
  input  wire stream_pkg::stream_config_t cfg_i,
  input  wire mem_pkg::mem_rd_rsp_t       mem_rd_rsp_i,
  output mem_pkg::mem_rd_req_t            mem_rd_req_o,
  output logic                            data_valid_o,
  output logic [DATA_WIDTH-1:0]           data_o,
  output logic                            finished_o
);

  stream_pkg::stream_flags_t gen_flags;
  logic [ADDR_WIDTH-1:0]     gen_addr;
  logic                      step;
  logic                      req_q;
  logic                      en_q;

  // Without back-pressure a read goes out on every cycle of the stream.
  assign step = en_i && gen_flags.in_progress;

  stream_addressgen #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .WORD_STRIDE  (WORD_STRIDE),
    .COUNTER_BITS (COUNTER_BITS)
  ) i_addrgen (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (en_i),
    .inc_i   (step),
    .cfg_i   (cfg_i),
    .addr_o  (gen_addr),
    .flags_o (gen_flags)
  );

  assign mem_rd_req_o.req  = step;
  assign mem_rd_req_o.addr = gen_addr;

  // Tracks the read still in flight, and whether enable was already high.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
      en_q  <= 1'b0;
    end else begin
      req_q <= step;
      en_q  <= en_i;
    end
  end

  // Read data goes straight on to the sink.
  assign data_valid_o = mem_rd_rsp_i.valid;
  assign data_o       = mem_rd_rsp_i.rdata;

  // The generator needs one enabled cycle before in_progress means anything.
  assign finished_o = en_q && !gen_flags.in_progress && !req_q;

  a_rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rd_rsp_i.valid |-> $past(mem_rd_req_o.req))
    else $error("Read response without a request in the previous cycle.");

endmodule

`default_nettype wire

// ==== sim/stream_copy_tb.sv ====
`default_nettype none

module stream_copy_tb;

  localparam logic [31:0] FILL_KEY    = 32'h3C5A_0000;
  localparam int unsigned WORD_STRIDE = 4;

  logic                       clk;
  logic                       rst_n;
  logic                       start_i;
  stream_pkg::stream_config_t src_cfg_i;
  stream_pkg::stream_config_t dst_cfg_i;
  mem_pkg::mem_rd_req_t       mem_rd_req;
  mem_pkg::mem_rd_rsp_t       mem_rd_rsp;
  mem_pkg::mem_wr_req_t       mem_wr_req;
  logic                       busy_o;
  logic                       done_o;
  int unsigned                wr_count;

  stream_pkg::stream_config_t cur_src;  // Configurations of the running copy.
  stream_pkg::stream_config_t cur_dst;
  mem_pkg::mem_wr_req_t       exp_wr;
  int unsigned                rd_index;
  int unsigned                wr_index;
  int unsigned                done_count;
  int unsigned                checks;
  int unsigned                errors;
  logic [15:0]                lfsr_q;
  logic [15:0]                size;

  stream_copy_top #(
    .ADDR_WIDTH   (32),
    .DATA_WIDTH   (32),
    .WORD_STRIDE  (WORD_STRIDE),
    .COUNTER_BITS (16)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .src_cfg_i    (src_cfg_i),
    .dst_cfg_i    (dst_cfg_i),
    .mem_rd_req_o (mem_rd_req),
    .mem_rd_rsp_i (mem_rd_rsp),
    .mem_wr_req_o (mem_wr_req),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  tb_memory #(.FILL_KEY(FILL_KEY)) mem_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_req_i   (mem_rd_req),
    .rd_rsp_o   (mem_rd_rsp),
    .wr_req_i   (mem_wr_req),
    .wr_count_o (wr_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return {addr[15:0], addr[31:16]} + FILL_KEY;
  endfunction

  // Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit taken.
  function automatic logic [31:0] take_bits(int unsigned n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic stream_pkg::stream_config_t make_config(
    logic [31:0] base, logic [15:0] tsize, logic [15:0] ll, logic signed [15:0] ls,
    logic [15:0] fl, logic signed [15:0] fs);
    stream_pkg::stream_config_t c;
    c.base_addr   = base;
    c.trans_size  = tsize;
    c.line_length = ll;
    c.line_stride = ls;
    c.feat_length = fl;
    c.feat_stride = fs;
    c.rsvd        = '0;
    return c;
  endfunction

  // Strides stay word multiples so every address is aligned.
  function automatic stream_pkg::stream_config_t random_config(logic [31:0] base,
                                                               logic [15:0] tsize);
    stream_pkg::stream_config_t c;
    logic [7:0]                 ls;
    logic [8:0]                 fs;
    c.base_addr   = base + (take_bits(8) << 2);
    c.trans_size  = tsize;
    c.line_length = 16'(take_bits(3)) + 16'd1;
    c.feat_length = 16'(take_bits(2)) + 16'd1;
    ls            = 8'(take_bits(8));
    fs            = 9'(take_bits(9));
    c.line_stride = {{6{ls[7]}}, ls, 2'b00};
    c.feat_stride = {{5{fs[8]}}, fs, 2'b00};
    c.rsvd        = '0;
    return c;
  endfunction

  function automatic logic [31:0] element_addr(stream_pkg::stream_config_t cfg, int unsigned k);
    int unsigned w;
    int unsigned l;
    int unsigned f;
    logic [31:0] ls;
    logic [31:0] fs;
    w  = k % cfg.line_length;
    l  = (k / cfg.line_length) % cfg.feat_length;
    f  = k / (cfg.line_length * cfg.feat_length);
    ls = {{16{cfg.line_stride[15]}}, cfg.line_stride};
    fs = {{16{cfg.feat_stride[15]}}, cfg.feat_stride};
    return cfg.base_addr + 32'(w) * 32'(WORD_STRIDE) + ls * 32'(l) + fs * 32'(f);
  endfunction

  // Write k lands at destination element k with the word of source element k.
  function automatic mem_pkg::mem_wr_req_t expected_write(stream_pkg::stream_config_t src,
                                                          stream_pkg::stream_config_t dst,
                                                          int unsigned k);
    mem_pkg::mem_wr_req_t w;
    w.req   = 1'b1;
    w.addr  = element_addr(dst, k);
    w.wdata = fill_word(element_addr(src, k));
    return w;
  endfunction

  task automatic check_addr(string name, logic [mem_pkg::ADDR_W-1:0] got,
                            logic [mem_pkg::ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(string name, logic [mem_pkg::DATA_W-1:0] got,
                            logic [mem_pkg::DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, logic [15:0] got, logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Checks: %0d, errors: %0d, run stopped early", checks, errors);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // Every access is checked mid-cycle, where the combinational outputs have settled.
  always @(negedge clk) begin
    if (rst_n && mem_rd_req.req) begin
      if (rd_index < cur_src.trans_size) begin
        check_addr("mem_rd_req_o.addr", mem_rd_req.addr, element_addr(cur_src, rd_index));
      end else begin
        errors++;
        $display("Read number %0d went past the transfer size of %0d at %0t.",
                 rd_index, cur_src.trans_size, $time);
      end
      rd_index++;
    end
    if (rst_n && mem_wr_req.req) begin
      if (wr_index < cur_src.trans_size) begin
        exp_wr = expected_write(cur_src, cur_dst, wr_index);
        check_addr("mem_wr_req_o.addr", mem_wr_req.addr, exp_wr.addr);
        check_data("mem_wr_req_o.wdata", mem_wr_req.wdata, exp_wr.wdata);
      end else begin
        errors++;
        $display("Write number %0d went past the transfer size of %0d at %0t.",
                 wr_index, cur_src.trans_size, $time);
      end
      wr_index++;
    end
    if (rst_n && done_o) begin
      done_count++;
      check_flag("busy_o", busy_o, 1'b0);  // Busy drops in the cycle of done.
    end
  end

  task automatic run_copy(stream_pkg::stream_config_t src, stream_pkg::stream_config_t dst,
                          logic restart, string label);
    int unsigned cycles;
    int unsigned limit;
    int unsigned mem_before;
    cur_src    = src;
    cur_dst    = dst;
    rd_index   = 0;
    wr_index   = 0;
    done_count = 0;
    mem_before = wr_count;
    limit      = 4 * src.trans_size + 40;
    @(negedge clk);
    src_cfg_i = src;
    dst_cfg_i = dst;
    start_i   = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    if (restart) begin
      // A second start with other settings while busy must be ignored.
      check_flag("busy_o", busy_o, 1'b1);
      src_cfg_i = ~src;
      dst_cfg_i = ~dst;
      start_i   = 1'b1;
      @(negedge clk);
      start_i = 1'b0;
    end
    cycles = 0;
    while (!done_o && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!done_o) begin
      fail_run($sformatf("The %s copy gave no done within %0d cycles.", label, limit));
    end
    repeat (3) @(negedge clk);
    check_count("read count", 16'(rd_index), src.trans_size);
    check_count("write count", 16'(wr_index), src.trans_size);
    check_count("memory write count", 16'(wr_count - mem_before), src.trans_size);
    check_count("done pulses", 16'(done_count), 16'd1);
    check_flag("busy_o", busy_o, 1'b0);
  endtask

  initial begin
    rst_n      = 1'b0;
    start_i    = 1'b0;
    src_cfg_i  = '0;
    dst_cfg_i  = '0;
    cur_src    = '0;
    cur_dst    = '0;
    rd_index   = 0;
    wr_index   = 0;
    done_count = 0;
    checks     = 0;
    errors     = 0;
    lfsr_q     = 16'd91;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("done_o", done_o, 1'b0);
    check_flag("mem_rd_req_o.req", mem_rd_req.req, 1'b0);
    check_flag("mem_wr_req_o.req", mem_wr_req.req, 1'b0);

    run_copy(make_config(32'h1000_0000, 16, 16, 64, 1, 64),
             make_config(32'h8000_0000, 16, 16, 64, 1, 64), 1'b0, "contiguous");
    run_copy(make_config(32'h1000_2000, 12, 4, -32, 3, 0),
             make_config(32'h8000_1000, 12, 3, 48, 4, 0), 1'b0, "2D");
    run_copy(make_config(32'h1000_4000, 30, 3, 16, 2, 256),
             make_config(32'h8000_4000, 30, 5, 40, 2, -512), 1'b0, "3D");
    for (int n = 0; n < 20; n++) begin
      size = 16'(take_bits(6));
      run_copy(random_config(32'h1000_8000, size), random_config(32'h8000_8000, size),
               1'b0, "random");
    end
    run_copy(make_config(32'h1000_C000, 20, 5, 20, 2, 100),
             make_config(32'h8000_C000, 20, 4, 32, 3, -64), 1'b1, "restarted");
    run_copy(make_config(32'h1000_0000, 0, 4, 16, 1, 0),
             make_config(32'h8000_0000, 0, 4, 16, 1, 0), 1'b0, "empty");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_memory.sv ====
`default_nettype none

module tb_memory #(
  parameter logic [31:0] FILL_KEY = 32'h3C5A_0000
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire mem_pkg::mem_rd_req_t rd_req_i,
  output mem_pkg::mem_rd_rsp_t      rd_rsp_o,
  input  wire mem_pkg::mem_wr_req_t wr_req_i,
  output int unsigned               wr_count_o
);

  logic [mem_pkg::DATA_W-1:0] store [logic [mem_pkg::ADDR_W-1:0]];

  // Words never written hold a value built from their own address.
  function automatic logic [mem_pkg::DATA_W-1:0] read_word(logic [mem_pkg::ADDR_W-1:0] addr);
    if (store.exists(addr)) begin
      return store[addr];
    end
    return {addr[15:0], addr[31:16]} + FILL_KEY;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_rsp_o   <= '0;
      wr_count_o <= 0;
    end else begin
      rd_rsp_o.valid <= rd_req_i.req;  // Every read is answered one cycle later.
      if (rd_req_i.req) begin
        rd_rsp_o.rdata <= read_word(rd_req_i.addr);
      end
      // A read in the same cycle as a write to that word sees the old value.
      if (wr_req_i.req) begin
        store[wr_req_i.addr] = wr_req_i.wdata;
        wr_count_o <= wr_count_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/stream_pkg.sv
design/mem_pkg.sv
design/stream_addressgen.sv
design/stream_source.sv
design/stream_sink.sv
design/stream_ctrl.sv
design/stream_copy_top.sv
sim/tb_memory.sv
sim/stream_copy_tb.sv
